// File: verif/csr_testdata.txt
// First value: number of blocks. Block header: base first count stride (hex)
// Then one line per index: expected index, expected request address
4
00001000 00000000 00000006 00000001
00000000 00001000
00000001 00001004
00000002 00001008
00000003 0000100C
00000004 00001010
00000005 00001014
20000000 00000003 00000005 00000002
00000003 2000000C
00000005 20000014
00000007 2000001C
00000009 20000024
0000000B 2000002C
00004000 00000010 00000000 00000001
00008000 00000001 00000008 00000003
00000001 00008004
00000004 00008010
00000007 0000801C
0000000A 00008028
0000000D 00008034
00000010 00008040
00000013 0000804C
00000016 00008058

// File: tb.f
source/csr_engine_pkg.sv
source/csr_index_config.sv
source/csr_index_generator.sv
source/csr_completion_queue.sv
source/engine_csr_index.sv
verif/tb_engine_csr_index.sv

// File: run.sh
#!/usr/bin/env bash
# Build the CSR index engine testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_engine_csr_index -f tb.f && \
./obj_dir/Vtb_engine_csr_index | tee /dev/stderr | \
    grep -F '*** PASSED ***' > /dev/null && \
    echo "Simulation passed" || \
    { echo "Simulation failed"; exit 1; }

// File: verif/tb_engine_csr_index.sv
/*
 * Testbench for the CSR index engine
 * Runs file driven configurations against a random memory and downstream
 */
`timescale 1ns/10ps

module tb_engine_csr_index;

    localparam int QUEUE_DEPTH = 4;
    localparam int RUN_TIMEOUT = 1000;
    localparam csr_engine_pkg::data_t DATA_OFFSET = 32'h1000_0000;

    logic                      ap_clk            = 1'b0;
    logic                      areset_csr_engine = 1'b1;
    logic                      cfg_we_i          = 1'b0;
    csr_engine_pkg::cfg_addr_t cfg_addr_i        = '0;
    csr_engine_pkg::cfg_word_t cfg_wdata_i       = '0;
    logic                      start_i           = 1'b0;
    logic                      mem_req_ready_i   = 1'b0;
    logic                      mem_rsp_valid_i   = 1'b0;
    csr_engine_pkg::data_t     mem_rsp_data_i    = '0;
    logic                      eng_req_ready_i   = 1'b0;
    logic                      mem_req_valid_o;
    csr_engine_pkg::addr_t     mem_req_addr_o;
    logic                      eng_req_valid_o;
    csr_engine_pkg::index_t    eng_req_index_o;
    csr_engine_pkg::data_t     eng_req_data_o;
    logic                      done_o;

    int                    seed          = 32'h23742162;
    int                    bus_cycle     = 0;
    int                    last_due      = 0;
    int                    accepted_cnt  = 0;
    int                    delivered_cnt = 0;
    int                    stall_peak    = 0;
    logic                  stall_eng     = 1'b0;
    logic                  req_held      = 1'b0;
    csr_engine_pkg::addr_t held_addr     = '0;
    logic [31:0]           tdata [0:127];

    // Expected traffic, and responses waiting in the memory model
    csr_engine_pkg::addr_t  exp_addr_q[$];
    csr_engine_pkg::index_t exp_eng_index_q[$];
    csr_engine_pkg::addr_t  exp_eng_addr_q[$];
    int                     rsp_due_q[$];
    csr_engine_pkg::data_t  rsp_data_q[$];

    engine_csr_index #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_engine_csr_index (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .cfg_we_i          (cfg_we_i),
        .cfg_addr_i        (cfg_addr_i),
        .cfg_wdata_i       (cfg_wdata_i),
        .start_i           (start_i),
        .mem_req_valid_o   (mem_req_valid_o),
        .mem_req_addr_o    (mem_req_addr_o),
        .mem_req_ready_i   (mem_req_ready_i),
        .mem_rsp_valid_i   (mem_rsp_valid_i),
        .mem_rsp_data_i    (mem_rsp_data_i),
        .eng_req_valid_o   (eng_req_valid_o),
        .eng_req_index_o   (eng_req_index_o),
        .eng_req_data_o    (eng_req_data_o),
        .eng_req_ready_i   (eng_req_ready_i),
        .done_o            (done_o)
    );

    always #5 ap_clk = ~ap_clk;

    // ----------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------
    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_addr(input csr_engine_pkg::addr_t got,
                              input csr_engine_pkg::addr_t exp, input string name);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s is %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_index(input csr_engine_pkg::index_t got,
                               input csr_engine_pkg::index_t exp, input string name);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s is %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_data(input csr_engine_pkg::data_t got,
                              input csr_engine_pkg::data_t exp, input string name);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s is %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_done(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s is %b, expected %b",
                                     $time, name, got, exp));
        end
    endtask

    task automatic write_cfg(input csr_engine_pkg::cfg_addr_t sel,
                             input csr_engine_pkg::cfg_word_t value);
        @(negedge ap_clk);
        cfg_we_i    = 1'b1;
        cfg_addr_i  = sel;
        cfg_wdata_i = value;
    endtask

    // Four reset cycles, then all outputs must be quiet
    task automatic apply_reset();
        areset_csr_engine = 1'b1;
        repeat (4) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_csr_engine = 1'b0;
        @(negedge ap_clk);
        check_done(mem_req_valid_o, 1'b0, "mem_req_valid_o");
        check_done(eng_req_valid_o, 1'b0, "eng_req_valid_o");
        check_done(done_o, 1'b0, "done_o");
    endtask

    // ----------------------------------------------------------
    // Memory model and downstream sink
    // ----------------------------------------------------------
    // Outputs are stable at the falling edge, so a handshake seen here
    // completes on the next rising edge
    always @(negedge ap_clk) begin : bus_model
        logic mem_fire;
        logic eng_fire;
        int   due;
        int   inflight;

        bus_cycle = bus_cycle + 1;
        if (rsp_due_q.size() != 0 && rsp_due_q[0] <= bus_cycle) begin
            mem_rsp_valid_i = 1'b1;
            mem_rsp_data_i  = rsp_data_q.pop_front();
            rsp_due_q.delete(0);
        end else begin
            mem_rsp_valid_i = 1'b0;
        end

        // A stalled request must hold
        if (req_held) begin
            if (mem_req_valid_o !== 1'b1) begin
                report_failure("memory request was dropped before it was accepted");
            end
            check_addr(mem_req_addr_o, held_addr, "mem_req_addr_o");
        end
        mem_req_ready_i = (($random(seed) & 3) != 0);
        mem_fire  = mem_req_valid_o && mem_req_ready_i;
        req_held  = mem_req_valid_o && !mem_req_ready_i;
        held_addr = mem_req_addr_o;
        if (mem_fire) begin
            if (exp_addr_q.size() == 0) begin
                report_failure("memory request with no expected address left");
            end
            check_addr(mem_req_addr_o, exp_addr_q.pop_front(), "mem_req_addr_o");
            // Responses return in order 0 to 3 cycles after acceptance
            due = bus_cycle + 1 + ($random(seed) & 3);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            rsp_due_q.push_back(due);
            rsp_data_q.push_back(csr_engine_pkg::data_t'(mem_req_addr_o) + DATA_OFFSET);
        end

        eng_req_ready_i = !stall_eng && (($random(seed) & 1) != 0);
        eng_fire = eng_req_valid_o && eng_req_ready_i;
        if (eng_fire) begin
            if (exp_eng_index_q.size() == 0) begin
                report_failure("engine output with no expected index left");
            end
            check_index(eng_req_index_o, exp_eng_index_q.pop_front(), "eng_req_index_o");
            check_data(eng_req_data_o,
                       csr_engine_pkg::data_t'(exp_eng_addr_q.pop_front()) + DATA_OFFSET,
                       "eng_req_data_o");
        end

        inflight = accepted_cnt - delivered_cnt + int'(mem_fire) - int'(eng_fire);
        if (inflight > QUEUE_DEPTH) begin
            report_failure("more requests in flight than the queue depth");
        end
        if (!stall_eng) begin
            stall_peak <= 0;
        end else if (inflight > stall_peak) begin
            stall_peak <= inflight;
        end
        if (mem_fire) begin
            accepted_cnt <= accepted_cnt + 1;
        end
        if (eng_fire) begin
            delivered_cnt <= delivered_cnt + 1;
        end
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin : main_seq
        int                     nblocks;
        int                     ptr;
        int                     total;
        int                     run_acc;
        int                     wait_cyc;
        logic                   stall_run;
        csr_engine_pkg::addr_t  base;
        csr_engine_pkg::index_t first;
        csr_engine_pkg::index_t count;
        csr_engine_pkg::index_t stride;
        csr_engine_pkg::index_t idx;
        csr_engine_pkg::addr_t  addr;

        $readmemh("verif/csr_testdata.txt", tdata);
        apply_reset();

        nblocks = int'(tdata[0]);
        ptr     = 1;
        total   = 0;
        for (int b = 0; b < nblocks; b++) begin
            base   = tdata[ptr];
            first  = tdata[ptr + 1];
            count  = tdata[ptr + 2];
            stride = tdata[ptr + 3];
            ptr    = ptr + 4;
            for (int i = 0; i < int'(count); i++) begin
                idx  = tdata[ptr];
                addr = tdata[ptr + 1];
                ptr  = ptr + 2;
                if (addr !== base + csr_engine_pkg::addr_t'(idx) *
                            csr_engine_pkg::addr_t'(csr_engine_pkg::ELEM_BYTES)) begin
                    report_failure($sformatf("test data address %h breaks the CSR rule", addr));
                end
                exp_addr_q.push_back(addr);
                exp_eng_index_q.push_back(idx);
                exp_eng_addr_q.push_back(addr);
            end

            // An empty range starts from a cleared done so it must raise done itself
            if (count == '0) begin
                apply_reset();
            end

            write_cfg(csr_engine_pkg::CFG_BASE, base);
            write_cfg(csr_engine_pkg::CFG_FIRST, first);
            write_cfg(csr_engine_pkg::CFG_COUNT, count);
            write_cfg(csr_engine_pkg::CFG_STRIDE, stride);
            // Long runs hold the downstream off to fill the queue
            stall_run = (count > csr_engine_pkg::index_t'(QUEUE_DEPTH));
            run_acc   = accepted_cnt;
            total     = total + int'(count);
            @(posedge ap_clk);
            stall_eng = stall_run;
            @(negedge ap_clk);
            cfg_we_i = 1'b0;
            start_i  = 1'b1;

            for (int cyc = 1; cyc <= 20; cyc++) begin
                @(negedge ap_clk);
                start_i  = 1'b0;
                cfg_we_i = 1'b0;
                if (count != '0) begin
                    // First request two cycles after start is sampled
                    if (cyc <= 3) begin
                        check_done(mem_req_valid_o, (cyc == 3), "mem_req_valid_o");
                    end
                    // Host writes during the run
                    if (cyc == 3) begin
                        write_cfg(csr_engine_pkg::CFG_BASE, 32'hDEAD_0000);
                    end else if (cyc == 4) begin
                        write_cfg(csr_engine_pkg::CFG_STRIDE, 32'h0000_0007);
                    end
                end else begin
                    check_done(mem_req_valid_o, 1'b0, "mem_req_valid_o");
                    // Done one cycle after the finish pulse of the empty range
                    check_done(done_o, (cyc >= 2), "done_o");
                end
            end
            if (stall_run) begin
                if (stall_peak != QUEUE_DEPTH) begin
                    report_failure("queue did not fill while the downstream stalled");
                end
                @(posedge ap_clk);
                stall_eng = 1'b0;
                @(negedge ap_clk);
            end

            wait_cyc = 0;
            while (!(delivered_cnt == total && done_o === 1'b1)) begin
                // Done follows the last engine handshake by one cycle
                if (accepted_cnt > run_acc) begin
                    check_done(done_o, (delivered_cnt == total), "done_o");
                end
                if (wait_cyc == RUN_TIMEOUT) begin
                    report_failure("timeout while waiting for the run to finish");
                end
                wait_cyc = wait_cyc + 1;
                @(negedge ap_clk);
            end
            if (accepted_cnt != total || exp_addr_q.size() != 0 ||
                exp_eng_index_q.size() != 0) begin
                report_failure("run finished with requests or outputs missing");
            end
            // Done holds with both channels quiet
            for (int cyc = 0; cyc < 3; cyc++) begin
                @(negedge ap_clk);
                check_done(done_o, 1'b1, "done_o");
                check_done(mem_req_valid_o, 1'b0, "mem_req_valid_o");
                check_done(eng_req_valid_o, 1'b0, "eng_req_valid_o");
            end
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule : tb_engine_csr_index

// File: source/engine_csr_index.sv
/*
 * CSR index engine top level
 * Configuration, index generation and completion queue in one pipeline
 */
`timescale 1ns/10ps

module engine_csr_index #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                      ap_clk,
    input  logic                      areset_csr_engine,
    input  logic                      cfg_we_i,
    input  csr_engine_pkg::cfg_addr_t cfg_addr_i,
    input  csr_engine_pkg::cfg_word_t cfg_wdata_i,
    input  logic                      start_i,
    output logic                      mem_req_valid_o,
    output csr_engine_pkg::addr_t     mem_req_addr_o,
    input  logic                      mem_req_ready_i,
    input  logic                      mem_rsp_valid_i,
    input  csr_engine_pkg::data_t     mem_rsp_data_i,
    output logic                      eng_req_valid_o,
    output csr_engine_pkg::index_t    eng_req_index_o,
    output csr_engine_pkg::data_t     eng_req_data_o,
    input  logic                      eng_req_ready_i,
    output logic                      done_o
);

    // ----------------------------------------------------------
    // Stage links
    // ----------------------------------------------------------
    logic                   cfg_start;
    csr_engine_pkg::addr_t  cfg_base;
    csr_engine_pkg::index_t cfg_first;
    csr_engine_pkg::index_t cfg_count;
    csr_engine_pkg::index_t cfg_stride;
    logic                   gen_busy;
    logic                   issue_fire;
    csr_engine_pkg::index_t issue_index;
    logic                   slot_free;
    logic                   gen_finished;

    csr_index_config u_config (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .cfg_we_i          (cfg_we_i),
        .cfg_addr_i        (cfg_addr_i),
        .cfg_wdata_i       (cfg_wdata_i),
        .start_i           (start_i),
        .gen_busy_i        (gen_busy),
        .cfg_start_o       (cfg_start),
        .cfg_base_o        (cfg_base),
        .cfg_first_o       (cfg_first),
        .cfg_count_o       (cfg_count),
        .cfg_stride_o      (cfg_stride)
    );

    // Queue done also releases the generator from WAIT_DONE
    csr_index_generator u_generator (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .cfg_start_i       (cfg_start),
        .cfg_base_i        (cfg_base),
        .cfg_first_i       (cfg_first),
        .cfg_count_i       (cfg_count),
        .cfg_stride_i      (cfg_stride),
        .mem_req_ready_i   (mem_req_ready_i),
        .slot_free_i       (slot_free),
        .queue_done_i      (done_o),
        .mem_req_valid_o   (mem_req_valid_o),
        .mem_req_addr_o    (mem_req_addr_o),
        .issue_fire_o      (issue_fire),
        .issue_index_o     (issue_index),
        .gen_busy_o        (gen_busy),
        .gen_finished_o    (gen_finished)
    );

    csr_completion_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .ap_clk            (ap_clk),
        .areset_csr_engine (areset_csr_engine),
        .issue_fire_i      (issue_fire),
        .issue_index_i     (issue_index),
        .mem_rsp_valid_i   (mem_rsp_valid_i),
        .mem_rsp_data_i    (mem_rsp_data_i),
        .eng_req_ready_i   (eng_req_ready_i),
        .gen_finished_i    (gen_finished),
        .slot_free_o       (slot_free),
        .eng_req_valid_o   (eng_req_valid_o),
        .eng_req_index_o   (eng_req_index_o),
        .eng_req_data_o    (eng_req_data_o),
        .done_o            (done_o)
    );

endmodule : engine_csr_index

// File: source/csr_completion_queue.sv
/*
 * In-order completion queue
 * Reserves a slot per request, pairs responses with indices, tracks done
 */
`timescale 1ns/10ps

module csr_completion_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                   ap_clk,
    input  logic                   areset_csr_engine,
    input  logic                   issue_fire_i,
    input  csr_engine_pkg::index_t issue_index_i,
    input  logic                   mem_rsp_valid_i,
    input  csr_engine_pkg::data_t  mem_rsp_data_i,
    input  logic                   eng_req_ready_i,
    input  logic                   gen_finished_i,
    output logic                   slot_free_o,
    output logic                   eng_req_valid_o,
    output csr_engine_pkg::index_t eng_req_index_o,
    output csr_engine_pkg::data_t  eng_req_data_o,
    output logic                   done_o
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    localparam logic [PTR_W-1:0] LAST_PTR  = PTR_W'(QUEUE_DEPTH - 1);
    localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(QUEUE_DEPTH);

    // Slot storage
    csr_engine_pkg::index_t index_mem [QUEUE_DEPTH];
    csr_engine_pkg::data_t  data_mem  [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0] filled_q;

    logic [PTR_W-1:0] rsv_ptr_q;
    logic [PTR_W-1:0] fill_ptr_q;
    logic [PTR_W-1:0] dlv_ptr_q;
    logic [CNT_W-1:0] occ_q;
    logic [CNT_W-1:0] occ_next;
    logic             eng_fire;
    logic             fin_q;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == LAST_PTR) ? '0 : ptr + PTR_W'(1);
    endfunction

    assign eng_fire = eng_req_valid_o && eng_req_ready_i;

    // Occupancy after this cycle's reservation and delivery
    always_comb begin
        occ_next = occ_q;
        if (issue_fire_i && !eng_fire) begin
            occ_next = occ_q + CNT_W'(1);
        end else if (!issue_fire_i && eng_fire) begin
            occ_next = occ_q - CNT_W'(1);
        end
    end

    assign slot_free_o = (occ_next < DEPTH_CNT);

    // ----------------------------------------------------------
    // Pointers and slot flags
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            rsv_ptr_q  <= '0;
            fill_ptr_q <= '0;
            dlv_ptr_q  <= '0;
            occ_q      <= '0;
            filled_q   <= '0;
        end else begin
            occ_q <= occ_next;
            if (issue_fire_i) begin
                rsv_ptr_q <= next_ptr(rsv_ptr_q);
            end
            if (mem_rsp_valid_i) begin
                filled_q[fill_ptr_q] <= 1'b1;
                fill_ptr_q           <= next_ptr(fill_ptr_q);
            end
            // Head slot is always filled here, never the fill slot
            if (eng_fire) begin
                filled_q[dlv_ptr_q] <= 1'b0;
                dlv_ptr_q           <= next_ptr(dlv_ptr_q);
            end
        end
    end

    // Payload
    always_ff @(posedge ap_clk) begin
        if (issue_fire_i) begin
            index_mem[rsv_ptr_q] <= issue_index_i;
        end
        if (mem_rsp_valid_i) begin
            data_mem[fill_ptr_q] <= mem_rsp_data_i;
        end
    end

    assign eng_req_valid_o = filled_q[dlv_ptr_q];
    assign eng_req_index_o = index_mem[dlv_ptr_q];
    assign eng_req_data_o  = data_mem[dlv_ptr_q];

    // ----------------------------------------------------------
    // Done tracking
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            fin_q  <= 1'b0;
            done_o <= 1'b0;
        end else begin
            if (gen_finished_i) begin
                fin_q <= 1'b1;
            end else if (issue_fire_i) begin
                fin_q <= 1'b0;
            end
            done_o <= (fin_q || gen_finished_i) && !issue_fire_i && (occ_next == '0);
        end
    end

    // Memory answers only requests that still own an unfilled slot
    a_rsp_has_slot: assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        mem_rsp_valid_i |-> !filled_q[fill_ptr_q] &&
                            (fill_ptr_q != rsv_ptr_q || occ_q == DEPTH_CNT)
    ) else $error("memory response without a reserved slot");

    // Generator honours the slot limit
    a_issue_has_slot: assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        issue_fire_i |-> occ_q < DEPTH_CNT || eng_fire
    ) else $error("request issued with the queue full");

endmodule : csr_completion_queue

// File: source/csr_index_generator.sv
/*
 * CSR index generator
 * Walks the index range and issues one memory read request per index
 */
`timescale 1ns/10ps

module csr_index_generator (
    input  logic                   ap_clk,
    input  logic                   areset_csr_engine,
    input  logic                   cfg_start_i,
    input  csr_engine_pkg::addr_t  cfg_base_i,
    input  csr_engine_pkg::index_t cfg_first_i,
    input  csr_engine_pkg::index_t cfg_count_i,
    input  csr_engine_pkg::index_t cfg_stride_i,
    input  logic                   mem_req_ready_i,
    input  logic                   slot_free_i,
    input  logic                   queue_done_i,
    output logic                   mem_req_valid_o,
    output csr_engine_pkg::addr_t  mem_req_addr_o,
    output logic                   issue_fire_o,
    output csr_engine_pkg::index_t issue_index_o,
    output logic                   gen_busy_o,
    output logic                   gen_finished_o
);

    csr_engine_pkg::gen_state_t state_q;

    logic                   req_valid_q;
    logic                   req_fire;
    logic                   last_fire;
    csr_engine_pkg::addr_t  addr_q;
    csr_engine_pkg::addr_t  addr_step_q;
    csr_engine_pkg::index_t index_q;
    csr_engine_pkg::index_t stride_q;
    csr_engine_pkg::index_t remaining_q;

    assign req_fire  = req_valid_q && mem_req_ready_i;
    assign last_fire = req_fire && (remaining_q == csr_engine_pkg::index_t'(1));

    // ----------------------------------------------------------
    // FSM and valid flag
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state_q     <= csr_engine_pkg::IDLE;
            req_valid_q <= 1'b0;
        end else begin
            case (state_q)
                csr_engine_pkg::IDLE: begin
                    req_valid_q <= 1'b0;
                    if (cfg_start_i) begin
                        if (cfg_count_i == '0) begin
                            state_q <= csr_engine_pkg::WAIT_DONE;
                        end else begin
                            state_q <= csr_engine_pkg::RUN;
                        end
                    end
                end
                csr_engine_pkg::RUN: begin
                    if (last_fire) begin
                        req_valid_q <= 1'b0;
                        state_q     <= csr_engine_pkg::WAIT_DONE;
                    end else if (!req_valid_q || req_fire) begin
                        // slot_free_i already counts a reservation made this cycle
                        req_valid_q <= slot_free_i;
                    end
                end
                csr_engine_pkg::WAIT_DONE: begin
                    req_valid_q <= 1'b0;
                    if (queue_done_i) begin
                        state_q <= csr_engine_pkg::IDLE;
                    end
                end
                default: begin
                    req_valid_q <= 1'b0;
                    state_q     <= csr_engine_pkg::IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------------------------
    // Index and address walk
    // ----------------------------------------------------------
    // Run parameters are captured at launch, so later host writes leave the run alone
    always_ff @(posedge ap_clk) begin
        if (state_q == csr_engine_pkg::IDLE && cfg_start_i) begin
            addr_q      <= cfg_base_i + csr_engine_pkg::addr_t'(cfg_first_i) *
                           csr_engine_pkg::addr_t'(csr_engine_pkg::ELEM_BYTES);
            addr_step_q <= csr_engine_pkg::addr_t'(cfg_stride_i) *
                           csr_engine_pkg::addr_t'(csr_engine_pkg::ELEM_BYTES);
            index_q     <= cfg_first_i;
            stride_q    <= cfg_stride_i;
            remaining_q <= cfg_count_i;
        end else if (req_fire) begin
            addr_q      <= addr_q + addr_step_q;
            index_q     <= index_q + stride_q;
            remaining_q <= remaining_q - csr_engine_pkg::index_t'(1);
        end
    end

    assign mem_req_valid_o = req_valid_q;
    assign mem_req_addr_o  = addr_q;
    assign issue_fire_o    = req_fire;
    assign issue_index_o   = index_q;
    assign gen_busy_o      = (state_q != csr_engine_pkg::IDLE);

    // Last accepted request, or straight away for an empty range
    assign gen_finished_o  = last_fire ||
                             (state_q == csr_engine_pkg::IDLE && cfg_start_i &&
                              cfg_count_i == '0);

    // Memory sees a steady request while it stalls
    a_req_stable: assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_addr_o)
    ) else $error("memory request changed under back-pressure");

endmodule : csr_index_generator

// File: source/csr_index_config.sv
/*
 * CSR index configuration stage
 * Holds the host registers and turns an accepted start into a launch pulse
 */
`timescale 1ns/10ps

module csr_index_config (
    input  logic                      ap_clk,
    input  logic                      areset_csr_engine,
    input  logic                      cfg_we_i,
    input  csr_engine_pkg::cfg_addr_t cfg_addr_i,
    input  csr_engine_pkg::cfg_word_t cfg_wdata_i,
    input  logic                      start_i,
    input  logic                      gen_busy_i,
    output logic                      cfg_start_o,
    output csr_engine_pkg::addr_t     cfg_base_o,
    output csr_engine_pkg::index_t    cfg_first_o,
    output csr_engine_pkg::index_t    cfg_count_o,
    output csr_engine_pkg::index_t    cfg_stride_o
);

    logic cfg_open;

    // Host access is open while the generator is idle and no launch is pending
    assign cfg_open = !gen_busy_i && !cfg_start_o;

    // ----------------------------------------------------------
    // Configuration registers
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            cfg_base_o   <= '0;
            cfg_first_o  <= '0;
            cfg_count_o  <= '0;
            cfg_stride_o <= '0;
        end else if (cfg_we_i && cfg_open) begin
            case (cfg_addr_i)
                csr_engine_pkg::CFG_BASE: begin
                    cfg_base_o <= csr_engine_pkg::addr_t'(cfg_wdata_i);
                end
                csr_engine_pkg::CFG_FIRST: begin
                    cfg_first_o <= csr_engine_pkg::index_t'(cfg_wdata_i);
                end
                csr_engine_pkg::CFG_COUNT: begin
                    cfg_count_o <= csr_engine_pkg::index_t'(cfg_wdata_i);
                end
                // CFG_STRIDE
                default: begin
                    cfg_stride_o <= csr_engine_pkg::index_t'(cfg_wdata_i);
                end
            endcase
        end
    end

    // ----------------------------------------------------------
    // Launch pulse
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            cfg_start_o <= 1'b0;
        end else begin
            cfg_start_o <= start_i && cfg_open;
        end
    end

    // Generator has to see each launch from IDLE
    a_launch_when_idle: assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        !(cfg_start_o && gen_busy_i)
    ) else $error("launch pulse while the generator is busy");

endmodule : csr_index_config

// File: source/csr_engine_pkg.sv
/*
 * Shared widths, types and encodings of the CSR index engine
 */
package csr_engine_pkg;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int INDEX_W    = 32;
    localparam int CFG_WORD_W = 32;

    // Bytes per CSR index entry in memory
    localparam int ELEM_BYTES = 4;

    // ----------------------------------------------------------
    // Data types
    // ----------------------------------------------------------
    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [CFG_WORD_W-1:0] cfg_word_t;

    // Configuration register select
    typedef logic [1:0] cfg_addr_t;

    localparam cfg_addr_t CFG_BASE   = 2'd0;
    localparam cfg_addr_t CFG_FIRST  = 2'd1;
    localparam cfg_addr_t CFG_COUNT  = 2'd2;
    localparam cfg_addr_t CFG_STRIDE = 2'd3;

    // ----------------------------------------------------------
    // Generator FSM
    // ----------------------------------------------------------
    // IDLE       waits for a launch
    // RUN        issues one memory request per index
    // WAIT_DONE  all requests accepted, waits for the queue to drain
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        RUN       = 2'd1,
        WAIT_DONE = 2'd2
    } gen_state_t;

endpackage : csr_engine_pkg
